//--- bench/cluster_stim.txt
// hart  we  addr  data      gap   (all hex)
// For a read line the data column holds the expected read value
0 1 0100 a0000011 0
1 1 0200 b1000022 1
2 1 0300 c2000033 0
3 1 0400 d3000044 2
0 0 0100 a0000011 1
1 0 0200 b1000022 0
2 1 0304 c2005555 0
3 0 0400 d3000044 0
0 1 0100 a00000ff 0
1 0 0204 00000000 2
2 0 0300 c2000033 1
3 1 0404 d30a0a0a 0
0 0 0100 a00000ff 0
1 1 0204 b1abcdef 0
2 0 0304 c2005555 3
3 1 0400 d3fedcba 1
0 0 0108 00000000 0
1 0 0204 b1abcdef 0
2 1 0300 c2777777 0
3 0 0400 d3fedcba 0

//--- bench/tb_hart_cluster.sv
// Testbench for the hart cluster
// Drives each hart port from the stimulus file, models the far clock
// domain with a memory behind both async FIFOs, and checks the results

`timescale 1ns/1ps
`default_nettype none

module tb_hart_cluster;

  import cluster_pkg::*;

  localparam int DEPTH        = 2**LOG_DEPTH;
  localparam int NUM_REQ      = 20;
  localparam int ACK_TIMEOUT  = 500;
  localparam int DONE_TIMEOUT = 3000;
  localparam int STALL_START  = 15;
  localparam int STALL_LEN    = 40;

  logic clk_i = 1'b0;
  logic rst_n_i;
  logic far_clk;
  logic far_stall;

  logic [NUM_HARTS-1:0]             wb_cyc;
  logic [NUM_HARTS-1:0]             wb_stb;
  logic [NUM_HARTS-1:0]             wb_we;
  logic [NUM_HARTS-1:0][ADDR_W-1:0] wb_adr;
  logic [NUM_HARTS-1:0][DATA_W-1:0] wb_dat_w;
  logic [NUM_HARTS-1:0][DATA_W-1:0] wb_dat_r;
  logic [NUM_HARTS-1:0]             wb_ack;
  logic [LOG_DEPTH:0]               req_wptr;
  logic [DEPTH*REQ_W-1:0]           req_data;
  logic [LOG_DEPTH:0]               req_rptr;
  logic [LOG_DEPTH:0]               rsp_wptr;
  logic [DEPTH*RSP_W-1:0]           rsp_data;
  logic [LOG_DEPTH:0]               rsp_rptr;
  logic [NUM_HARTS-1:0]             hart_done;

  // Five hex words per request for hart, we, addr, data and gap
  logic [31:0] stim_mem [0:NUM_REQ*5-1];

  // Far-side model state
  logic [LOG_DEPTH:0]  req_rbin;
  logic [LOG_DEPTH:0]  rsp_wbin;
  logic [LOG_DEPTH:0]  req_w_s1;
  logic [LOG_DEPTH:0]  req_w_s2;
  logic [LOG_DEPTH:0]  rsp_r_s1;
  logic [LOG_DEPTH:0]  rsp_r_s2;
  logic [15:0]         lfsr;
  logic [DATA_W-1:0]   far_mem [logic [ADDR_W-1:0]];
  int                  far_tags [$];
  int                  far_reads;

  // Monitor state
  logic [LOG_DEPTH:0]  req_wptr_prev;
  logic [LOG_DEPTH:0]  rsp_rptr_prev;
  int                  adv_cnt;
  int                  ack_cnt [NUM_HARTS];

  hart_cluster #(
    .NUM_HARTS ( NUM_HARTS ),
    .LOG_DEPTH ( LOG_DEPTH )
  ) dut0 (
    .clk_i      ( clk_i    ),
    .rst_n_i    ( rst_n_i  ),
    .wb_cyc_i   ( wb_cyc   ),
    .wb_stb_i   ( wb_stb   ),
    .wb_we_i    ( wb_we    ),
    .wb_adr_i   ( wb_adr   ),
    .wb_dat_i   ( wb_dat_w ),
    .wb_dat_o   ( wb_dat_r ),
    .wb_ack_o   ( wb_ack   ),
    .req_wptr_o ( req_wptr ),
    .req_data_o ( req_data ),
    .req_rptr_i ( req_rptr ),
    .rsp_wptr_i ( rsp_wptr ),
    .rsp_data_i ( rsp_data ),
    .rsp_rptr_o ( rsp_rptr )
  );

  always #5 clk_i = ~clk_i;

  // Far clock offset keeps its edges off the hart clock edges
  initial begin : p_far_clk
    far_clk = 1'b0;
    #1.5;
    forever #7 far_clk = ~far_clk;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic stop_on_failure();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped after the first failure");
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s (got %0h, expected %0h)", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    stop_on_failure();
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [LOG_DEPTH:0] gray_to_bin(input logic [LOG_DEPTH:0] g);
    logic [LOG_DEPTH:0] b;
    b[LOG_DEPTH] = g[LOG_DEPTH];
    for (int i = LOG_DEPTH - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // --------------------
  // Hart masters
  // --------------------
  for (genvar g = 0; g < NUM_HARTS; g++) begin : gen_drv
    logic              cyc_d;
    logic              stb_d;
    logic              we_d;
    logic [ADDR_W-1:0] adr_d;
    logic [DATA_W-1:0] dat_d;
    logic              done_d;

    assign wb_cyc[g]    = cyc_d;
    assign wb_stb[g]    = stb_d;
    assign wb_we[g]     = we_d;
    assign wb_adr[g]    = adr_d;
    assign wb_dat_w[g]  = dat_d;
    assign hart_done[g] = done_d;

    initial begin : p_hart
      int waited;
      int gap;
      cyc_d  = 1'b0;
      stb_d  = 1'b0;
      we_d   = 1'b0;
      adr_d  = '0;
      dat_d  = '0;
      done_d = 1'b0;
      // First negedge after reset release
      repeat (4) @(negedge clk_i);
      for (int n = 0; n < NUM_REQ; n++) begin
        if (int'(stim_mem[n*5]) == g) begin
          cyc_d  = 1'b1;
          stb_d  = 1'b1;
          we_d   = stim_mem[n*5+1][0];
          adr_d  = stim_mem[n*5+2][ADDR_W-1:0];
          dat_d  = stim_mem[n*5+3];
          gap    = int'(stim_mem[n*5+4]);
          waited = 0;
          @(negedge clk_i);
          while (!wb_ack[g]) begin
            if (waited == ACK_TIMEOUT) begin
              report_timeout($sformatf("hart %0d got no ack for stimulus line %0d", g, n));
            end
            waited++;
            @(negedge clk_i);
          end
          // Data column of a read line is the expected value
          if (!we_d) begin
            check_value(64'(wb_dat_r[g]), 64'(dat_d),
                        $sformatf("hart %0d read data at address %0h", g, adr_d));
          end
          cyc_d = 1'b0;
          stb_d = 1'b0;
          repeat (gap) @(negedge clk_i);
        end
      end
      done_d = 1'b1;
    end
  end

  // --------------------
  // Far-side model
  // --------------------
  initial begin : p_far
    logic [REQ_W-1:0]     word;
    logic [HART_ID_W-1:0] tag;
    logic [ADDR_W-1:0]    addr;
    logic [DATA_W-1:0]    rdata;
    logic [LOG_DEPTH:0]   used;
    logic                 take;
    int                   idx;
    req_rptr  = '0;
    rsp_wptr  = '0;
    rsp_data  = '0;
    req_rbin  = '0;
    rsp_wbin  = '0;
    req_w_s1  = '0;
    req_w_s2  = '0;
    rsp_r_s1  = '0;
    rsp_r_s2  = '0;
    lfsr      = 16'd16938;
    far_reads = 0;
    forever begin
      @(negedge far_clk);
      if (rst_n_i) begin
        req_w_s2 = req_w_s1;
        req_w_s1 = req_wptr;
        rsp_r_s2 = rsp_r_s1;
        rsp_r_s1 = rsp_rptr;
        used     = rsp_wbin - gray_to_bin(rsp_r_s2);
        take     = lfsr[0];
        lfsr     = lfsr_next(lfsr);
        if (take && !far_stall && req_w_s2 != req_rptr && int'(used) < DEPTH) begin
          idx  = int'(req_rbin[LOG_DEPTH-1:0]) * REQ_W;
          word = req_data[idx +: REQ_W];
          tag  = word[REQ_ID_LSB +: HART_ID_W];
          addr = word[REQ_ADR_LSB +: ADDR_W];
          if (word[REQ_WE_BIT]) begin
            far_mem[addr] = word[DATA_W-1:0];
            rdata         = '0;
          end else begin
            rdata = far_mem.exists(addr) ? far_mem[addr] : '0;
          end
          // Answer in order with the tag copied
          idx                    = int'(rsp_wbin[LOG_DEPTH-1:0]) * RSP_W;
          rsp_data[idx +: RSP_W] = {tag, rdata};
          rsp_wbin               = rsp_wbin + (LOG_DEPTH+1)'(1);
          rsp_wptr               = rsp_wbin ^ (rsp_wbin >> 1);
          req_rbin               = req_rbin + (LOG_DEPTH+1)'(1);
          req_rptr               = req_rbin ^ (req_rbin >> 1);
          far_tags.push_back(int'(tag));
          far_reads++;
        end
      end
    end
  end

  // Pointer steps, FIFO occupancy bound and ack counts
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (req_wptr != req_wptr_prev) begin
        check_value(64'($countones(req_wptr ^ req_wptr_prev)), 64'd1,
                    "req_wptr_o changed in more than one bit");
        adv_cnt++;
        check_value(64'(adv_cnt <= far_reads + DEPTH), 64'd1,
                    "request pointer ran ahead of far-side reads by more than the depth");
      end
      if (rsp_rptr != rsp_rptr_prev) begin
        check_value(64'($countones(rsp_rptr ^ rsp_rptr_prev)), 64'd1,
                    "rsp_rptr_o changed in more than one bit");
      end
      for (int h = 0; h < NUM_HARTS; h++) begin
        if (wb_ack[h]) begin
          ack_cnt[h]++;
        end
      end
    end
    req_wptr_prev = req_wptr;
    rsp_rptr_prev = rsp_rptr;
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin : p_main
    int waited;
    int exp_cnt;
    rst_n_i   = 1'b0;
    far_stall = 1'b0;
    $readmemh("bench/cluster_stim.txt", stim_mem);
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    check_value(64'(wb_ack), 64'd0, "wb_ack_o not zero after reset");
    check_value(64'(req_wptr), 64'd0, "req_wptr_o not zero after reset");
    check_value(64'(rsp_rptr), 64'd0, "rsp_rptr_o not zero after reset");

    // Far side stops reading mid-run so the request FIFO fills
    repeat (STALL_START) @(negedge clk_i);
    far_stall = 1'b1;
    repeat (STALL_LEN) @(negedge clk_i);
    @(posedge clk_i);
    check_value(64'(adv_cnt), 64'(far_reads + DEPTH),
                "request FIFO did not fill while the far side was stalled");
    @(negedge clk_i);
    far_stall = 1'b0;

    waited = 0;
    while (!(&hart_done)) begin
      if (waited == DONE_TIMEOUT) begin
        report_timeout("not every hart finished its requests");
      end
      waited++;
      @(negedge clk_i);
    end
    // Room for any stray ack to show up
    repeat (10) @(negedge clk_i);
    @(posedge clk_i);

    for (int h = 0; h < NUM_HARTS; h++) begin
      exp_cnt = 0;
      for (int n = 0; n < NUM_REQ; n++) begin
        if (int'(stim_mem[n*5]) == h) begin
          exp_cnt++;
        end
      end
      check_value(64'(ack_cnt[h]), 64'(exp_cnt), $sformatf("ack count of hart %0d", h));
    end
    check_value(64'(adv_cnt), 64'(NUM_REQ), "number of request pointer advances");
    check_value(64'(far_tags.size()), 64'(NUM_REQ), "number of requests read by far side");
    // All harts start together and hart 0 leads the rotation
    for (int i = 0; i < NUM_HARTS; i++) begin
      check_value(64'(far_tags[i]), 64'(i), $sformatf("tag of request word %0d", i));
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/cdc_gray_dst.sv
// Async FIFO read half
// Syncs the far write pointer, pops one response per cycle while not
// empty and turns the hart tag into a one-hot valid

`timescale 1ns/1ps
`default_nettype none

module cdc_gray_dst #(
  parameter int unsigned NUM_HARTS = cluster_pkg::NUM_HARTS,
  parameter int unsigned LOG_DEPTH = cluster_pkg::LOG_DEPTH
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  logic [LOG_DEPTH:0]                          wptr_i,
  input  logic [(2**LOG_DEPTH)*cluster_pkg::RSP_W-1:0] data_i,
  output logic [LOG_DEPTH:0]                          rptr_o,
  output logic [NUM_HARTS-1:0]                        rsp_valid_o,
  output logic [cluster_pkg::DATA_W-1:0]              rsp_data_o
);

  import cluster_pkg::*;

  logic [LOG_DEPTH:0]     wptr_s1_q;
  logic [LOG_DEPTH:0]     wptr_s2_q;
  logic [LOG_DEPTH:0]     rbin_q;
  logic [LOG_DEPTH:0]     rgray_q;
  logic [LOG_DEPTH:0]     rbin_next;
  logic [LOG_DEPTH-1:0]   raddr;
  logic [RSP_W-1:0]       entry;
  logic [HART_ID_W-1:0]   tag;
  logic [NUM_HARTS-1:0]   valid_d;
  logic                   empty;

  assign raddr     = rbin_q[LOG_DEPTH-1:0];
  assign rbin_next = rbin_q + (LOG_DEPTH+1)'(1);
  assign empty     = (wptr_s2_q == rgray_q);
  assign entry     = data_i[raddr*RSP_W +: RSP_W];
  assign tag       = entry[RSP_ID_LSB +: HART_ID_W];
  assign rptr_o    = rgray_q;

  // Every tagged hart waits and takes its entry at once
  always_comb begin
    valid_d = '0;
    if (!empty) begin
      valid_d[tag] = 1'b1;
    end
  end

  // --------------------
  // Write pointer sync
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_s1_q <= '0;
      wptr_s2_q <= '0;
    end else begin
      wptr_s1_q <= wptr_i;
      wptr_s2_q <= wptr_s1_q;
    end
  end

  // --------------------
  // Pop and deliver
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rbin_q      <= '0;
      rgray_q     <= '0;
      rsp_valid_o <= '0;
      rsp_data_o  <= '0;
    end else begin
      rsp_valid_o <= valid_d;
      if (!empty) begin
        rsp_data_o <= entry[DATA_W-1:0];
        rbin_q     <= rbin_next;
        rgray_q    <= rbin_next ^ (rbin_next >> 1);
      end
    end
  end

endmodule

`default_nettype wire

//--- design/cdc_gray_src.sv
// Async FIFO write half
// Storage and gray write pointer live here; the read pointer comes back
// from the far domain through a two-flop synchronizer

`timescale 1ns/1ps
`default_nettype none

module cdc_gray_src #(
  parameter int unsigned LOG_DEPTH = cluster_pkg::LOG_DEPTH,
  parameter int unsigned WIDTH     = cluster_pkg::REQ_W
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              push_i,
  input  logic [WIDTH-1:0]                  push_data_i,
  output logic                              full_o,
  output logic [LOG_DEPTH:0]                wptr_o,
  output logic [(2**LOG_DEPTH)*WIDTH-1:0]   data_o,
  input  logic [LOG_DEPTH:0]                rptr_i
);

  localparam int unsigned DEPTH = 2**LOG_DEPTH;
  // Full when only the top two gray bits differ
  localparam logic [LOG_DEPTH:0] FULL_MASK = (LOG_DEPTH+1)'(3) << (LOG_DEPTH - 1);

  logic [DEPTH*WIDTH-1:0] data_q;
  logic [LOG_DEPTH:0]     wbin_q;
  logic [LOG_DEPTH:0]     wgray_q;
  logic [LOG_DEPTH:0]     wbin_next;
  logic [LOG_DEPTH:0]     wgray_next;
  logic [LOG_DEPTH-1:0]   waddr;
  logic [LOG_DEPTH:0]     rptr_s1_q;
  logic [LOG_DEPTH:0]     rptr_s2_q;
  logic                   do_push;

  assign waddr      = wbin_q[LOG_DEPTH-1:0];
  assign wbin_next  = wbin_q + (LOG_DEPTH+1)'(1);
  assign wgray_next = wbin_next ^ (wbin_next >> 1);

  assign full_o  = ((wgray_q ^ rptr_s2_q) == FULL_MASK);
  assign do_push = push_i && !full_o;

  assign wptr_o = wgray_q;
  assign data_o = data_q;

  // --------------------
  // Read pointer sync
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rptr_s1_q <= '0;
      rptr_s2_q <= '0;
    end else begin
      rptr_s1_q <= rptr_i;
      rptr_s2_q <= rptr_s1_q;
    end
  end

  // --------------------
  // Write side
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wbin_q  <= '0;
      wgray_q <= '0;
      data_q  <= '0;
    end else if (do_push) begin
      // Entry is written before the pointer that exposes it
      data_q[waddr*WIDTH +: WIDTH] <= push_data_i;
      wbin_q                       <= wbin_next;
      wgray_q                      <= wgray_next;
    end
  end

endmodule

`default_nettype wire

//--- design/cluster_pkg.sv
// Cluster package
// Widths, request and response word layout, and sizes derived from them
// for the hart cluster and its clock-crossing link

`default_nettype none

package cluster_pkg;

  // --------------------
  // Basic sizes
  // --------------------
  parameter int unsigned NUM_HARTS = 4;
  parameter int unsigned ADDR_W    = 16;
  parameter int unsigned DATA_W    = 32;
  // FIFO holds 2**LOG_DEPTH entries
  parameter int unsigned LOG_DEPTH = 1;

  // Hart tag at least one bit wide
  parameter int unsigned HART_ID_W = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1;

  // --------------------
  // Request word
  // --------------------
  // Hart id on top, then write flag, address and write data
  parameter int unsigned REQ_ADR_LSB = DATA_W;
  parameter int unsigned REQ_WE_BIT  = DATA_W + ADDR_W;
  parameter int unsigned REQ_ID_LSB  = DATA_W + ADDR_W + 1;
  parameter int unsigned REQ_W       = HART_ID_W + 1 + ADDR_W + DATA_W;

  // --------------------
  // Response word
  // --------------------
  // Hart id on top of the read data
  parameter int unsigned RSP_ID_LSB = DATA_W;
  parameter int unsigned RSP_W      = HART_ID_W + DATA_W;

endpackage

`default_nettype wire

//--- design/hart_cluster.sv
// Hart cluster
// Per-hart Wishbone ports share one outgoing link through a round-robin
// arbiter and a gray-pointer async FIFO, responses return through another

`timescale 1ns/1ps
`default_nettype none

module hart_cluster #(
  parameter int unsigned NUM_HARTS = cluster_pkg::NUM_HARTS,
  parameter int unsigned LOG_DEPTH = cluster_pkg::LOG_DEPTH
) (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // Hart side
  input  logic [NUM_HARTS-1:0]                          wb_cyc_i,
  input  logic [NUM_HARTS-1:0]                          wb_stb_i,
  input  logic [NUM_HARTS-1:0]                          wb_we_i,
  input  logic [NUM_HARTS-1:0][cluster_pkg::ADDR_W-1:0] wb_adr_i,
  input  logic [NUM_HARTS-1:0][cluster_pkg::DATA_W-1:0] wb_dat_i,
  output logic [NUM_HARTS-1:0][cluster_pkg::DATA_W-1:0] wb_dat_o,
  output logic [NUM_HARTS-1:0]                          wb_ack_o,
  // Request link to the far domain
  output logic [LOG_DEPTH:0]                            req_wptr_o,
  output logic [(2**LOG_DEPTH)*cluster_pkg::REQ_W-1:0]  req_data_o,
  input  logic [LOG_DEPTH:0]                            req_rptr_i,
  // Response link from the far domain
  input  logic [LOG_DEPTH:0]                            rsp_wptr_i,
  input  logic [(2**LOG_DEPTH)*cluster_pkg::RSP_W-1:0]  rsp_data_i,
  output logic [LOG_DEPTH:0]                            rsp_rptr_o
);

  import cluster_pkg::*;

  logic [NUM_HARTS-1:0]             pend;
  logic [NUM_HARTS-1:0]             grant;
  logic [NUM_HARTS-1:0]             we;
  logic [NUM_HARTS-1:0][ADDR_W-1:0] adr;
  logic [NUM_HARTS-1:0][DATA_W-1:0] dat;
  logic                             push;
  logic [REQ_W-1:0]                 push_data;
  logic                             full;
  logic [NUM_HARTS-1:0]             rsp_valid;
  logic [DATA_W-1:0]                rsp_data;

  // --------------------
  // Hart ports
  // --------------------
  for (genvar h = 0; h < NUM_HARTS; h++) begin : gen_hart
    hart_port #(
      .NUM_HARTS ( NUM_HARTS ),
      .HART_IDX  ( h         )
    ) u_port (
      .clk_i       ( clk_i       ),
      .rst_n_i     ( rst_n_i     ),
      .wb_cyc_i    ( wb_cyc_i[h] ),
      .wb_stb_i    ( wb_stb_i[h] ),
      .wb_we_i     ( wb_we_i[h]  ),
      .wb_adr_i    ( wb_adr_i[h] ),
      .wb_dat_i    ( wb_dat_i[h] ),
      .wb_dat_o    ( wb_dat_o[h] ),
      .wb_ack_o    ( wb_ack_o[h] ),
      .pend_o      ( pend[h]     ),
      .we_o        ( we[h]       ),
      .adr_o       ( adr[h]      ),
      .dat_o       ( dat[h]      ),
      .grant_i     ( grant[h]    ),
      .rsp_valid_i ( rsp_valid   ),
      .rsp_data_i  ( rsp_data    )
    );
  end

  req_arbiter #(
    .NUM_HARTS ( NUM_HARTS )
  ) u_arb (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .pend_i      ( pend      ),
    .we_i        ( we        ),
    .adr_i       ( adr       ),
    .dat_i       ( dat       ),
    .grant_o     ( grant     ),
    .full_i      ( full      ),
    .push_o      ( push      ),
    .push_data_o ( push_data )
  );

  // --------------------
  // Clock crossing
  // --------------------
  cdc_gray_src #(
    .LOG_DEPTH ( LOG_DEPTH ),
    .WIDTH     ( REQ_W     )
  ) u_req_src (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .push_i      ( push       ),
    .push_data_i ( push_data  ),
    .full_o      ( full       ),
    .wptr_o      ( req_wptr_o ),
    .data_o      ( req_data_o ),
    .rptr_i      ( req_rptr_i )
  );

  cdc_gray_dst #(
    .NUM_HARTS ( NUM_HARTS ),
    .LOG_DEPTH ( LOG_DEPTH )
  ) u_rsp_dst (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .wptr_i      ( rsp_wptr_i ),
    .data_i      ( rsp_data_i ),
    .rptr_o      ( rsp_rptr_o ),
    .rsp_valid_o ( rsp_valid  ),
    .rsp_data_o  ( rsp_data   )
  );

endmodule

`default_nettype wire

//--- design/hart_port.sv
// Hart port
// Wishbone classic slave for one hart: holds a single request, offers it
// to the arbiter and acks once the tagged response comes back

`timescale 1ns/1ps
`default_nettype none

module hart_port #(
  parameter int unsigned NUM_HARTS = cluster_pkg::NUM_HARTS,
  parameter int unsigned HART_IDX  = 0
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           wb_cyc_i,
  input  logic                           wb_stb_i,
  input  logic                           wb_we_i,
  input  logic [cluster_pkg::ADDR_W-1:0] wb_adr_i,
  input  logic [cluster_pkg::DATA_W-1:0] wb_dat_i,
  output logic [cluster_pkg::DATA_W-1:0] wb_dat_o,
  output logic                           wb_ack_o,
  output logic                           pend_o,
  output logic                           we_o,
  output logic [cluster_pkg::ADDR_W-1:0] adr_o,
  output logic [cluster_pkg::DATA_W-1:0] dat_o,
  input  logic                           grant_i,
  input  logic [NUM_HARTS-1:0]           rsp_valid_i,
  input  logic [cluster_pkg::DATA_W-1:0] rsp_data_i
);

  typedef enum logic [1:0] {ST_IDLE, ST_PEND, ST_WAIT} state_e;

  state_e state_q;
  logic   rsp_hit;

  // Only our own bit of the one-hot response vector
  assign rsp_hit = rsp_valid_i[HART_IDX];
  assign pend_o  = (state_q == ST_PEND);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_IDLE;
      we_o     <= 1'b0;
      adr_o    <= '0;
      dat_o    <= '0;
      wb_dat_o <= '0;
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          // Master still holds the finished request during the ack cycle
          if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
            we_o    <= wb_we_i;
            adr_o   <= wb_adr_i;
            dat_o   <= wb_dat_i;
            state_q <= ST_PEND;
          end
        end
        ST_PEND: begin
          if (grant_i) begin
            state_q <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (rsp_hit) begin
            wb_dat_o <= rsp_data_i;
            wb_ack_o <= 1'b1;
            state_q  <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/req_arbiter.sv
// Request arbiter
// Round-robin choice among pending harts, tags the winner with its index
// and pushes the packed request word into the request FIFO

`timescale 1ns/1ps
`default_nettype none

module req_arbiter #(
  parameter int unsigned NUM_HARTS = cluster_pkg::NUM_HARTS
) (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic [NUM_HARTS-1:0]                          pend_i,
  input  logic [NUM_HARTS-1:0]                          we_i,
  input  logic [NUM_HARTS-1:0][cluster_pkg::ADDR_W-1:0] adr_i,
  input  logic [NUM_HARTS-1:0][cluster_pkg::DATA_W-1:0] dat_i,
  output logic [NUM_HARTS-1:0]                          grant_o,
  input  logic                                          full_i,
  output logic                                          push_o,
  output logic [cluster_pkg::REQ_W-1:0]                 push_data_o
);

  import cluster_pkg::*;

  logic [HART_ID_W-1:0] last_q;
  logic [HART_ID_W-1:0] win;
  logic                 found;

  // --------------------
  // Winner search
  // --------------------
  // Scan starts one past the last grant and wraps
  always_comb begin : p_search
    int cand;
    found = 1'b0;
    win   = '0;
    for (int k = 1; k <= int'(NUM_HARTS); k++) begin
      cand = (int'(last_q) + k) % int'(NUM_HARTS);
      if (!found && pend_i[cand]) begin
        found = 1'b1;
        win   = cand[HART_ID_W-1:0];
      end
    end
  end

  assign push_o = found && !full_i;

  always_comb begin
    grant_o = '0;
    if (push_o) begin
      grant_o[win] = 1'b1;
    end
  end

  // Request word packing
  always_comb begin
    push_data_o                            = '0;
    push_data_o[REQ_ID_LSB +: HART_ID_W]   = win;
    push_data_o[REQ_WE_BIT]                = we_i[win];
    push_data_o[REQ_ADR_LSB +: ADDR_W]     = adr_i[win];
    push_data_o[DATA_W-1:0]                = dat_i[win];
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // Highest index lets hart 0 go first
      last_q <= HART_ID_W'(NUM_HARTS - 1);
    end else if (push_o) begin
      last_q <= win;
    end
  end

endmodule

`default_nettype wire

//--- list.f
design/cluster_pkg.sv
design/hart_port.sv
design/req_arbiter.sv
design/cdc_gray_src.sv
design/cdc_gray_dst.sv
design/hart_cluster.sv
bench/tb_hart_cluster.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the hart cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_hart_cluster -Mdir obj_dir -f list.f

# A failing run exits non-zero, the search below decides the result
out=$(./obj_dir/Vtb_hart_cluster) || true
echo "$out"

if grep -qxF "Done: no errors" <<< "$out"; then
  exit 0
fi
exit 1
